/* source/dbg_ctrl_pkg.sv */
`default_nettype none

package dbg_ctrl_pkg;

    // Mode select and command code share one encoding
    typedef logic [7:0] mode_t;

    // Single-step sequence, then hold while the command stays asserted
    typedef enum logic [2:0] {
        IDLE,       // Waiting for a command match
        CLK_LOW,    // cpu_clk setup, still low
        CLK_HIGH,   // Pulse requested
        CLK_DONE,   // Pulse returns low
        RUN         // Report running or finished
    } step_e;

endpackage

`default_nettype wire

/* source/dbg_print_pkg.sv */
`default_nettype none

package dbg_print_pkg;

    localparam int FIELD_COUNT = 9;
    localparam int LABEL_MAX   = 3;   // Longest label, NPC/CTL/IMM/MDR

    // Print order of the datapath report
    typedef enum logic [3:0] {
        FLD_NPC,
        FLD_PC,
        FLD_IR,
        FLD_CTL,
        FLD_A,
        FLD_B,
        FLD_IMM,
        FLD_Y,
        FLD_MDR
    } field_e;

    typedef logic [7:0] char_t;

    localparam char_t CHAR_EQ = 8'h3D;
    localparam char_t CHAR_CR = 8'h0D;
    localparam char_t CHAR_LF = 8'h0A;

    localparam logic [1:0] LABEL_LEN [FIELD_COUNT] = '{
        2'd3, 2'd2, 2'd2, 2'd3, 2'd1, 2'd1, 2'd3, 2'd1, 2'd3
    };

    // Unused tail characters are padded with NUL
    localparam char_t LABEL_CHARS [FIELD_COUNT][LABEL_MAX] = '{
        '{"N", "P", "C"},
        '{"P", "C", 8'h00},
        '{"I", "R", 8'h00},
        '{"C", "T", "L"},
        '{"A", 8'h00, 8'h00},
        '{"B", 8'h00, 8'h00},
        '{"I", "M", "M"},
        '{"Y", 8'h00, 8'h00},
        '{"M", "D", "R"}
    };

    // 19 label chars, 9 '=', 9 values, CR and LF
    localparam int ITEM_COUNT = 39;

endpackage

`default_nettype wire

/* source/dbg_step_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_step_ctrl
    import dbg_ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        rstn,
    input  wire mode_t sel_mode,
    input  wire mode_t cmd_code,
    output logic       cpu_clk,
    output logic       run
);

    step_e state;
    step_e state_nxt;
    logic  cmd_hit;

    assign cmd_hit = (sel_mode == cmd_code);

    // The step itself always completes once started
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (cmd_hit) begin
                    state_nxt = CLK_LOW;
                end
            end
            CLK_LOW: begin
                state_nxt = CLK_HIGH;
            end
            CLK_HIGH: begin
                state_nxt = CLK_DONE;
            end
            CLK_DONE: begin
                state_nxt = RUN;
            end
            RUN: begin
                if (!cmd_hit) begin
                    state_nxt = IDLE;   // Rearm for the next command
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= IDLE;
            cpu_clk <= 1'b0;
            run     <= 1'b0;
        end else begin
            state   <= state_nxt;
            cpu_clk <= (state == CLK_HIGH);         // One cycle wide
            run     <= (state == RUN) && cmd_hit;   // Drops right after withdrawal
        end
    end

endmodule

`default_nettype wire

/* source/dbg_field_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_field_seq
    import dbg_print_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  wire               clk,
    input  wire               rstn,
    input  wire               run,
    input  wire [DATA_W-1:0]  npc,
    input  wire [DATA_W-1:0]  pc,
    input  wire [DATA_W-1:0]  ir,
    input  wire [DATA_W-1:0]  ctl,
    input  wire [DATA_W-1:0]  a,
    input  wire [DATA_W-1:0]  b,
    input  wire [DATA_W-1:0]  imm,
    input  wire [DATA_W-1:0]  y,
    input  wire [DATA_W-1:0]  mdr,
    input  wire               item_ready,
    output logic              item_valid,
    output logic [DATA_W-1:0] item_data,
    output logic              item_is_value,
    output logic              item_last
);

    typedef enum logic [1:0] {
        PH_LABEL,
        PH_EQ,
        PH_VALUE,
        PH_END
    } phase_e;

    localparam int CHR_W = $clog2(LABEL_MAX);

    logic [DATA_W-1:0] snap [FIELD_COUNT];
    field_e            fld;
    field_e            fld_nxt;
    phase_e            phase;
    phase_e            phase_nxt;
    logic [CHR_W-1:0]  chr;
    logic [CHR_W-1:0]  chr_nxt;
    logic              started;
    logic              done;
    logic              start;
    logic              load;
    logic [DATA_W-1:0] cur_data;
    logic              cur_is_value;
    logic              cur_last;

    assign start = run && !started;
    assign load  = run && (!started || (!done && (!item_valid || item_ready)));

    // Item at the pointer, and where the pointer goes after it
    always_comb begin
        cur_data     = '0;
        cur_is_value = 1'b0;
        cur_last     = 1'b0;
        fld_nxt      = fld;
        phase_nxt    = phase;
        chr_nxt      = chr;
        case (phase)
            PH_LABEL: begin
                cur_data = DATA_W'(LABEL_CHARS[fld][chr]);
                if (chr == LABEL_LEN[fld] - 2'd1) begin
                    phase_nxt = PH_EQ;
                    chr_nxt   = '0;
                end else begin
                    chr_nxt = chr + 1'b1;
                end
            end
            PH_EQ: begin
                cur_data  = DATA_W'(CHAR_EQ);
                phase_nxt = PH_VALUE;
            end
            PH_VALUE: begin
                cur_data     = snap[fld];
                cur_is_value = 1'b1;
                if (fld == FLD_MDR) begin
                    phase_nxt = PH_END;
                end else begin
                    fld_nxt   = field_e'(fld + 1'b1);
                    phase_nxt = PH_LABEL;
                end
            end
            default: begin
                cur_data = (chr == '0) ? DATA_W'(CHAR_CR) : DATA_W'(CHAR_LF);
                cur_last = (chr != '0);
                chr_nxt  = chr + 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            started    <= 1'b0;
            done       <= 1'b0;
            item_valid <= 1'b0;
            fld        <= FLD_NPC;
            phase      <= PH_LABEL;
            chr        <= '0;
        end else if (!run) begin   // Abort or end of command, rewind
            started    <= 1'b0;
            done       <= 1'b0;
            item_valid <= 1'b0;
            fld        <= FLD_NPC;
            phase      <= PH_LABEL;
            chr        <= '0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end
            if (load) begin
                item_valid <= 1'b1;
                fld        <= fld_nxt;
                phase      <= phase_nxt;
                chr        <= chr_nxt;
                done       <= cur_last;
            end else if (item_ready) begin
                item_valid <= 1'b0;   // LF taken, idle until run drops
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            snap[FLD_NPC] <= npc;
            snap[FLD_PC]  <= pc;
            snap[FLD_IR]  <= ir;
            snap[FLD_CTL] <= ctl;
            snap[FLD_A]   <= a;
            snap[FLD_B]   <= b;
            snap[FLD_IMM] <= imm;
            snap[FLD_Y]   <= y;
            snap[FLD_MDR] <= mdr;
        end
        if (load) begin
            item_data     <= cur_data;
            item_is_value <= cur_is_value;
            item_last     <= cur_last;
        end
    end

endmodule

`default_nettype wire

/* source/dbg_tx_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_tx_port #(
    parameter int DATA_W = 32
) (
    input  wire               clk,
    input  wire               rstn,
    input  wire               run,
    input  wire               item_valid,
    input  wire [DATA_W-1:0]  item_data,
    input  wire               item_is_value,
    input  wire               item_last,
    output logic              item_ready,
    input  wire               tx_ack,
    output logic              tx_req,
    output logic [DATA_W-1:0] tx_data,
    output logic              tx_is_value,
    output logic              finish
);

    logic full;
    logic held_last;
    logic take;
    logic ack;

    assign tx_req     = full;
    assign item_ready = !full;
    assign take       = item_valid && item_ready;
    assign ack        = full && tx_ack;   // Ack without req is ignored

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            full   <= 1'b0;
            finish <= 1'b0;
        end else if (!run) begin
            full   <= 1'b0;
            finish <= 1'b0;
        end else begin
            if (ack) begin
                full <= 1'b0;   // Empty for one cycle before the next take
                if (held_last) begin
                    finish <= 1'b1;
                end
            end else if (take) begin
                full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            tx_data     <= item_data;
            tx_is_value <= item_is_value;
            held_last   <= item_last;
        end
    end

endmodule

`default_nettype wire

/* source/dbg_print_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_print_top
    import dbg_ctrl_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  wire               clk,
    input  wire               rstn,
    input  wire mode_t        sel_mode,
    input  wire mode_t        cmd_code,
    input  wire [DATA_W-1:0]  npc,
    input  wire [DATA_W-1:0]  pc,
    input  wire [DATA_W-1:0]  ir,
    input  wire [DATA_W-1:0]  ctl,
    input  wire [DATA_W-1:0]  a,
    input  wire [DATA_W-1:0]  b,
    input  wire [DATA_W-1:0]  imm,
    input  wire [DATA_W-1:0]  y,
    input  wire [DATA_W-1:0]  mdr,
    input  wire               tx_ack,
    output logic              cpu_clk,
    output logic              tx_req,
    output logic              tx_is_value,
    output logic [DATA_W-1:0] tx_data,
    output logic              finish
);

    logic              run;
    logic              item_valid;
    logic              item_ready;
    logic [DATA_W-1:0] item_data;
    logic              item_is_value;
    logic              item_last;

    dbg_step_ctrl u_step (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .cmd_code (cmd_code),
        .cpu_clk  (cpu_clk),
        .run      (run)
    );

    dbg_field_seq #(
        .DATA_W (DATA_W)
    ) u_seq (
        .clk           (clk),
        .rstn          (rstn),
        .run           (run),
        .npc           (npc),
        .pc            (pc),
        .ir            (ir),
        .ctl           (ctl),
        .a             (a),
        .b             (b),
        .imm           (imm),
        .y             (y),
        .mdr           (mdr),
        .item_ready    (item_ready),
        .item_valid    (item_valid),
        .item_data     (item_data),
        .item_is_value (item_is_value),
        .item_last     (item_last)
    );

    dbg_tx_port #(
        .DATA_W (DATA_W)
    ) u_tx (
        .clk           (clk),
        .rstn          (rstn),
        .run           (run),
        .item_valid    (item_valid),
        .item_data     (item_data),
        .item_is_value (item_is_value),
        .item_last     (item_last),
        .item_ready    (item_ready),
        .tx_ack        (tx_ack),
        .tx_req        (tx_req),
        .tx_data       (tx_data),
        .tx_is_value   (tx_is_value),
        .finish        (finish)
    );

endmodule

`default_nettype wire

/* verif/dbg_print_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_print_asserts #(
    parameter int DATA_W = 32
) (
    input wire              clk,
    input wire              rstn,
    input wire              cpu_clk,
    input wire              tx_req,
    input wire              tx_ack,
    input wire [DATA_W-1:0] tx_data,
    input wire              tx_is_value,
    input wire              finish
);

    int fail_count = 0;

    // Payload frozen while the receiver has not acked
    hold_while_waiting: assert property (@(posedge clk) disable iff (!rstn)
        tx_req && !tx_ack |=> $stable(tx_data) && $stable(tx_is_value))
    else begin
        $error("tx payload changed while waiting for tx_ack");
        fail_count++;
    end

    req_drops_after_ack: assert property (@(posedge clk) disable iff (!rstn)
        tx_req && tx_ack |=> !tx_req)
    else begin
        $error("tx_req not low in the cycle after an ack");
        fail_count++;
    end

    single_step_pulse: assert property (@(posedge clk) disable iff (!rstn)
        cpu_clk |=> !cpu_clk)
    else begin
        $error("cpu_clk high for more than one cycle");
        fail_count++;
    end

    finish_quiet: assert property (@(posedge clk) disable iff (!rstn)
        finish |-> !tx_req)
    else begin
        $error("tx_req high while finish is set");
        fail_count++;
    end

endmodule

bind dbg_print_top dbg_print_asserts #(
    .DATA_W (DATA_W)
) u_asserts (
    .clk         (clk),
    .rstn        (rstn),
    .cpu_clk     (cpu_clk),
    .tx_req      (tx_req),
    .tx_ack      (tx_ack),
    .tx_data     (tx_data),
    .tx_is_value (tx_is_value),
    .finish      (finish)
);

`default_nettype wire

/* verif/tb_dbg_print.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_print
    import dbg_print_pkg::*;
();

    localparam int DATA_W      = 32;
    localparam int NUM_ROWS    = 6;
    localparam int REQ_TIMEOUT = 200;
    localparam int PULSE_AT    = 3;    // Match edge, then two cycles
    localparam int IDLE_WINDOW = 40;

    logic              clk;
    logic              rstn;
    logic [7:0]        sel_mode;
    logic [7:0]        cmd_code;
    logic [DATA_W-1:0] fields [FIELD_COUNT];
    logic              tx_ack;
    logic              cpu_clk;
    logic              tx_req;
    logic              tx_is_value;
    logic [DATA_W-1:0] tx_data;
    logic              finish;

    logic [31:0]       lfsr;
    logic [DATA_W-1:0] exp_data  [ITEM_COUNT];
    logic              exp_value [ITEM_COUNT];

    // Name, command, mode, abort item (-1 for none), random ack delay
    string      row_name  [NUM_ROWS] = '{"imm_ack", "rand_ack", "abort_mid",
                                         "restart", "no_match", "abort_cr"};
    logic [7:0] row_cmd   [NUM_ROWS] = '{8'h5A, 8'hC3, 8'h21, 8'h21, 8'h7E, 8'h90};
    logic [7:0] row_mode  [NUM_ROWS] = '{8'h5A, 8'hC3, 8'h21, 8'h21, 8'h7F, 8'h90};
    int         row_abort [NUM_ROWS] = '{-1, -1, 17, -1, -1, 37};
    logic       row_rand  [NUM_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    dbg_print_top #(
        .DATA_W (DATA_W)
    ) uut (
        .clk         (clk),
        .rstn        (rstn),
        .sel_mode    (sel_mode),
        .cmd_code    (cmd_code),
        .npc         (fields[0]),
        .pc          (fields[1]),
        .ir          (fields[2]),
        .ctl         (fields[3]),
        .a           (fields[4]),
        .b           (fields[5]),
        .imm         (fields[6]),
        .y           (fields[7]),
        .mdr         (fields[8]),
        .tx_ack      (tx_ack),
        .cpu_clk     (cpu_clk),
        .tx_req      (tx_req),
        .tx_is_value (tx_is_value),
        .tx_data     (tx_data),
        .finish      (finish)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string name, input string what,
                            input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        stop_run($sformatf("MISMATCH %s %s expected %h actual %h", name, what, exp, act));
    endtask

    // Labels, '=', value per field, then CR LF
    task automatic build_expected(output int count);
        int f;
        int c;
        count = 0;
        for (f = 0; f < FIELD_COUNT; f++) begin
            for (c = 0; c < LABEL_LEN[f]; c++) begin
                exp_data[count]  = DATA_W'(LABEL_CHARS[f][c]);
                exp_value[count] = 1'b0;
                count++;
            end
            exp_data[count]  = DATA_W'(CHAR_EQ);
            exp_value[count] = 1'b0;
            count++;
            exp_data[count]  = fields[f];
            exp_value[count] = 1'b1;
            count++;
        end
        exp_data[count]      = DATA_W'(CHAR_CR);
        exp_value[count]     = 1'b0;
        exp_data[count + 1]  = DATA_W'(CHAR_LF);
        exp_value[count + 1] = 1'b0;
        count += 2;
    endtask

    task automatic wait_req(input string name, input int idx);
        int n;
        n = 0;
        @(negedge clk);
        while (!tx_req) begin
            n++;
            assert (n < REQ_TIMEOUT)
                else stop_run($sformatf("%s: no tx_req for item %0d", name, idx));
            @(negedge clk);
        end
    endtask

    task automatic wait_finish(input string name, input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (finish != level) begin
            n++;
            assert (n < REQ_TIMEOUT)
                else stop_run($sformatf("%s: finish never went to %0b", name, level));
            @(negedge clk);
        end
    endtask

    task automatic abort_report(input string name, input logic [7:0] cmd);
        int n;
        @(posedge clk);
        sel_mode <= ~cmd;
        n = 0;
        @(negedge clk);
        while (tx_req) begin
            n++;
            assert (n < 3)
                else stop_run($sformatf("%s: tx_req still high after abort", name));
            @(negedge clk);
        end
        repeat (8) begin
            @(negedge clk);
            assert (!finish && !tx_req)
                else stop_run($sformatf("%s: activity after the print was aborted", name));
        end
    endtask

    task automatic run_row(input int r);
        string name;
        int    count;
        int    k;
        int    f;
        int    delay;
        name = row_name[r];
        @(posedge clk);
        cmd_code <= row_cmd[r];
        sel_mode <= ~row_cmd[r];
        tx_ack   <= 1'b0;
        for (f = 0; f < FIELD_COUNT; f++) begin
            fields[f] <= rand_bits(DATA_W);
        end
        repeat (2) @(posedge clk);
        build_expected(count);
        assert (count == ITEM_COUNT)
            else mismatch(name, "item count", ITEM_COUNT, count);
        tx_ack   <= !row_rand[r];   // Held high for immediate acks
        sel_mode <= row_mode[r];

        if (row_mode[r] != row_cmd[r]) begin
            repeat (IDLE_WINDOW) begin
                @(negedge clk);
                assert (!cpu_clk && !tx_req)
                    else stop_run($sformatf("%s: step or print without a match", name));
            end
            @(posedge clk);
            sel_mode <= ~row_cmd[r];
            tx_ack   <= 1'b0;
            return;
        end

        for (k = 0; k < PULSE_AT + 3; k++) begin
            @(negedge clk);
            assert (cpu_clk == (k == PULSE_AT))
                else mismatch(name, $sformatf("cpu_clk cycle %0d", k), k == PULSE_AT, cpu_clk);
            assert (!tx_req)
                else stop_run($sformatf("%s: tx_req before the step pulse ended", name));
        end

        for (k = 0; k < ITEM_COUNT; k++) begin
            wait_req(name, k);
            assert (tx_is_value == exp_value[k])
                else mismatch(name, $sformatf("item %0d kind", k), exp_value[k], tx_is_value);
            assert (tx_data == exp_data[k])
                else mismatch(name, $sformatf("item %0d data", k), exp_data[k], tx_data);
            if (k == row_abort[r]) begin
                abort_report(name, row_cmd[r]);
                return;
            end
            if (row_rand[r]) begin
                delay = rand_bits(2);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                tx_ack <= 1'b1;
                @(posedge clk);
                tx_ack <= 1'b0;
            end else begin
                @(posedge clk);
            end
            if (k == 0) begin
                for (f = 0; f < FIELD_COUNT; f++) begin
                    fields[f] <= rand_bits(DATA_W);   // Live values now differ
                end
            end
        end

        wait_finish(name, 1'b1);
        repeat (10) begin
            @(negedge clk);
            assert (finish && !tx_req)
                else stop_run($sformatf("%s: finish dropped or new tx_req while held", name));
        end
        @(posedge clk);
        sel_mode <= ~row_cmd[r];
        tx_ack   <= 1'b0;
        wait_finish(name, 1'b0);
    endtask

    initial begin
        int i;
        lfsr     = 32'h3f08;
        rstn     = 1'b0;
        sel_mode = 8'h00;
        cmd_code = 8'hFF;
        tx_ack   = 1'b0;
        for (i = 0; i < FIELD_COUNT; i++) begin
            fields[i] = '0;
        end
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (!cpu_clk && !tx_req && !finish)
            else stop_run("outputs not idle after reset");
        for (i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        repeat (4) @(posedge clk);
        if (uut.u_asserts.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_run("bound handshake assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

/* sim.f */
source/dbg_ctrl_pkg.sv
source/dbg_print_pkg.sv
source/dbg_step_ctrl.sv
source/dbg_field_seq.sv
source/dbg_tx_port.sv
source/dbg_print_top.sv
verif/dbg_print_asserts.sv
verif/tb_dbg_print.sv
